// ==== hw/spu_pkg.sv ====
package spu_pkg;

	// register count is fixed by the instruction set
	localparam int NUM_REGS = 128;

	// bit 0 is the msb, as in the isa tables
	typedef logic [0:31] instr_t;
	typedef logic [0:31] word_t;
	// slot 0 is the preferred slot
	typedef word_t [0:3] quad_t;
	typedef logic [0:6] reg_addr_t;
	typedef logic [7:0] pc_t;
	// immediate after sign extension to the widest (ri18) field
	typedef logic [0:17] imm_t;

	// even pipe ops, word-wise fixed point only
	typedef enum logic [3:0] {
		EOP_NOP, EOP_A, EOP_AH, EOP_SF,
		EOP_AND, EOP_OR, EOP_XOR, EOP_NAND,
		EOP_AI, EOP_ANDI, EOP_ORI, EOP_ILA
	} even_op_e;

	// odd pipe ops, branch unit only
	typedef enum logic [2:0] {
		OOP_LNOP, OOP_BR, OOP_BRA, OOP_BRZ, OOP_BRNZ
	} odd_op_e;

	typedef struct packed {
		even_op_e op;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
		imm_t imm;
		logic reg_write;
	} even_uop_t;

	// rt doubles as the condition register for brz and brnz
	typedef struct packed {
		odd_op_e op;
		reg_addr_t rt;
		imm_t imm;
	} odd_uop_t;

	typedef struct packed {
		logic valid;
		reg_addr_t addr;
		quad_t data;
	} wb_t;

	// rr format, 11 bit opcode field
	localparam logic [0:10] OPC_A = 11'b00011000000;
	localparam logic [0:10] OPC_AH = 11'b00011001000;
	localparam logic [0:10] OPC_SF = 11'b00001000000;
	localparam logic [0:10] OPC_AND = 11'b00011000001;
	localparam logic [0:10] OPC_OR = 11'b00001000001;
	localparam logic [0:10] OPC_XOR = 11'b01001000001;
	localparam logic [0:10] OPC_NAND = 11'b00011001001;
	localparam logic [0:10] OPC_NOP = 11'b01000000001;
	localparam logic [0:10] OPC_LNOP = 11'b00000000001;
	// ri16 branches, 9 bit field
	localparam logic [0:8] OPC_BR = 9'b001100100;
	localparam logic [0:8] OPC_BRA = 9'b001100000;
	localparam logic [0:8] OPC_BRZ = 9'b001000000;
	localparam logic [0:8] OPC_BRNZ = 9'b001000010;
	// ri10, 8 bit field
	localparam logic [0:7] OPC_AI = 8'b00011100;
	localparam logic [0:7] OPC_ANDI = 8'b00010100;
	localparam logic [0:7] OPC_ORI = 8'b00000100;
	// ri18, 7 bit field
	localparam logic [0:6] OPC_ILA = 7'b0100001;

endpackage

// ==== hw/spu_decode.sv ====
`timescale 1ns/10ps

module spu_decode import spu_pkg::*; (
	input instr_t instr_even,
	input instr_t instr_odd,
	output even_uop_t uop_even,
	output odd_uop_t uop_odd
);

	// per-format match results, EOP_NOP means no hit
	even_op_e rr_op;
	even_op_e ri10_op;

	// rr opcodes, longest field so checked first
	always_comb begin
		case (instr_even[0:10])
			OPC_A: rr_op = EOP_A;
			OPC_AH: rr_op = EOP_AH;
			OPC_SF: rr_op = EOP_SF;
			OPC_AND: rr_op = EOP_AND;
			OPC_OR: rr_op = EOP_OR;
			OPC_XOR: rr_op = EOP_XOR;
			OPC_NAND: rr_op = EOP_NAND;
			// explicit even nop
			OPC_NOP: rr_op = EOP_NOP;
			default: rr_op = EOP_NOP;
		endcase
	end

	// ri10 opcodes
	always_comb begin
		case (instr_even[0:7])
			OPC_AI: ri10_op = EOP_AI;
			OPC_ANDI: ri10_op = EOP_ANDI;
			OPC_ORI: ri10_op = EOP_ORI;
			default: ri10_op = EOP_NOP;
		endcase
	end

	// even uop assembly
	always_comb begin
		// zero word and unknown ops fall out as a no-write nop
		uop_even = '0;
		if (rr_op != EOP_NOP) begin
			uop_even.op = rr_op;
			uop_even.rb = instr_even[11:17];
			uop_even.ra = instr_even[18:24];
			uop_even.rt = instr_even[25:31];
			uop_even.reg_write = 1'b1;
		end else if (ri10_op != EOP_NOP) begin
			uop_even.op = ri10_op;
			uop_even.ra = instr_even[18:24];
			uop_even.rt = instr_even[25:31];
			// i10 sits in bits 8..17
			uop_even.imm = {{8{instr_even[8]}}, instr_even[8:17]};
			uop_even.reg_write = 1'b1;
		end else if (instr_even[0:6] == OPC_ILA) begin
			uop_even.op = EOP_ILA;
			uop_even.rt = instr_even[25:31];
			// i18 fills the immediate exactly
			uop_even.imm = instr_even[7:24];
			uop_even.reg_write = 1'b1;
		end
	end

	// odd uop assembly, branches never write
	always_comb begin
		uop_odd = '0;
		if (instr_odd[0:10] == OPC_LNOP) begin
			uop_odd.op = OOP_LNOP;
		end else begin
			case (instr_odd[0:8])
				OPC_BR: uop_odd.op = OOP_BR;
				OPC_BRA: uop_odd.op = OOP_BRA;
				OPC_BRZ: uop_odd.op = OOP_BRZ;
				OPC_BRNZ: uop_odd.op = OOP_BRNZ;
				default: uop_odd.op = OOP_LNOP;
			endcase
			// only real branches carry fields
			if (uop_odd.op != OOP_LNOP) begin
				uop_odd.rt = instr_odd[25:31];
				// i16 in bits 9..24
				uop_odd.imm = {{2{instr_odd[9]}}, instr_odd[9:24]};
			end
		end
	end

endmodule

// ==== hw/spu_reg_table.sv ====
`timescale 1ns/10ps

module spu_reg_table import spu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input reg_addr_t ra_addr,
	input reg_addr_t rb_addr,
	// odd pipe condition register
	input reg_addr_t rc_addr,
	output quad_t ra,
	output quad_t rb,
	output quad_t rc,
	input wb_t wb
);

	// 128 x 128 bit register table
	quad_t regs [NUM_REGS];

	// single write port, fed from even ex2
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// all registers start at zero
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// async reads
	// even operands
	assign ra = regs[ra_addr];
	assign rb = regs[rb_addr];
	// odd condition operand
	assign rc = regs[rc_addr];

	// x on the write enable would corrupt a random entry
	wb_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(wb.valid)
	) else $error("writeback valid is unknown");

endmodule

// ==== hw/spu_forward.sv ====
`timescale 1ns/10ps

module spu_forward import spu_pkg::*; (
	input reg_addr_t ra_addr,
	input reg_addr_t rb_addr,
	input reg_addr_t rc_addr,
	input quad_t ra_raw,
	input quad_t rb_raw,
	input quad_t rc_raw,
	// in-flight even results, ex1 is the younger
	input wb_t ex1,
	input wb_t ex2,
	output quad_t ra,
	output quad_t rb,
	output quad_t rc
);

	// newest matching tap wins over the table read
	function automatic quad_t pick(
		input reg_addr_t addr,
		input quad_t raw,
		input wb_t t1,
		input wb_t t2
	);
		quad_t val;
		val = raw;
		// r0 never bypasses
		if (addr != '0) begin
			if (t1.valid && t1.addr == addr) begin
				val = t1.data;
			end else if (t2.valid && t2.addr == addr) begin
				val = t2.data;
			end
		end
		return val;
	endfunction

	// even pipe operands
	assign ra = pick(ra_addr, ra_raw, ex1, ex2);
	assign rb = pick(rb_addr, rb_raw, ex1, ex2);

	// brz / brnz condition word
	assign rc = pick(rc_addr, rc_raw, ex1, ex2);

endmodule

// ==== hw/spu_even_pipe.sv ====
`timescale 1ns/10ps

module spu_even_pipe import spu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input even_uop_t uop,
	// forwarded operands
	input quad_t ra,
	input quad_t rb,
	output wb_t ex1,
	output wb_t ex2
);

	// immediate as a full word, sign and zero extended
	word_t imm_sext;
	word_t imm_zext;
	// execute result for the current uop
	quad_t res;

	assign imm_sext = {{14{uop.imm[0]}}, uop.imm};
	// ila takes the raw 18 bits
	assign imm_zext = {14'b0, uop.imm};

	// fixed point unit, one pass per word slot
	always_comb begin
		res = '0;
		for (int w = 0; w < 4; w++) begin
			case (uop.op)
				EOP_A: res[w] = ra[w] + rb[w];
				EOP_AH: begin
					// two separate halves so carry stops at bit 16
					res[w][0:15] = ra[w][0:15] + rb[w][0:15];
					res[w][16:31] = ra[w][16:31] + rb[w][16:31];
				end
				// subtract from: rt = rb - ra
				EOP_SF: res[w] = rb[w] - ra[w];
				EOP_AND: res[w] = ra[w] & rb[w];
				EOP_OR: res[w] = ra[w] | rb[w];
				EOP_XOR: res[w] = ra[w] ^ rb[w];
				EOP_NAND: res[w] = ~(ra[w] & rb[w]);
				// immediate forms replicate into every slot
				EOP_AI: res[w] = ra[w] + imm_sext;
				EOP_ANDI: res[w] = ra[w] & imm_sext;
				EOP_ORI: res[w] = ra[w] | imm_sext;
				EOP_ILA: res[w] = imm_zext;
				default: res[w] = '0;
			endcase
		end
	end

	// two result stages, ex2 is the writeback stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex1 <= '0;
			ex2 <= '0;
		end else begin
			ex1.valid <= uop.reg_write;
			ex1.addr <= uop.rt;
			ex1.data <= res;
			ex2 <= ex1;
		end
	end

	// writeback must come from a valid ex1 entry
	ex2_from_ex1: assert property (
		@(posedge clk) disable iff (!rst_n)
		ex2.valid |-> $past(ex1.valid)
	) else $error("ex2 valid without prior ex1 valid");

endmodule

// ==== hw/spu_odd_pipe.sv ====
`timescale 1ns/10ps

module spu_odd_pipe import spu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input odd_uop_t uop,
	// fetch pc of the current pair
	input pc_t pc,
	// forwarded condition register
	input quad_t cond,
	output logic branch_taken,
	output pc_t pc_wb
);

	logic taken_next;
	pc_t target_next;
	// low byte of the branch immediate
	pc_t offset;

	assign offset = uop.imm[10:17];

	// branch resolution
	always_comb begin
		taken_next = 1'b0;
		target_next = pc + offset;
		case (uop.op)
			OOP_BR: taken_next = 1'b1;
			OOP_BRA: begin
				// absolute target
				taken_next = 1'b1;
				target_next = offset;
			end
			// condition is the preferred slot only
			OOP_BRZ: taken_next = (cond[0] == '0);
			OOP_BRNZ: taken_next = (cond[0] != '0);
			default: taken_next = 1'b0;
		endcase
	end

	// one cycle pulse, target held between branches
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			branch_taken <= 1'b0;
			pc_wb <= '0;
		end else begin
			branch_taken <= taken_next;
			if (taken_next) begin
				pc_wb <= target_next;
			end
		end
	end

	// lnop must never produce a redirect
	lnop_no_branch: assert property (
		@(posedge clk) disable iff (!rst_n)
		uop.op == OOP_LNOP |=> !branch_taken
	) else $error("branch taken after lnop");

endmodule

// ==== hw/spu_pipes.sv ====
`timescale 1ns/10ps

module spu_pipes import spu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input instr_t instr_even,
	input instr_t instr_odd,
	input pc_t pc,
	// even ex2, also the table write port
	output wb_t wb_even,
	output logic branch_taken,
	output pc_t pc_wb
);

	even_uop_t uop_even;
	odd_uop_t uop_odd;
	// raw table reads
	quad_t ra_raw;
	quad_t rb_raw;
	quad_t rc_raw;
	// operands after bypass
	quad_t ra_fwd;
	quad_t rb_fwd;
	quad_t rc_fwd;
	// younger in-flight even result
	wb_t even_ex1;

	spu_decode u_decode (
		.instr_even(instr_even),
		.instr_odd(instr_odd),
		.uop_even(uop_even),
		.uop_odd(uop_odd)
	);

	spu_reg_table u_reg_table (
		.clk(clk),
		.rst_n(rst_n),
		.ra_addr(uop_even.ra),
		.rb_addr(uop_even.rb),
		.rc_addr(uop_odd.rt),
		.ra(ra_raw),
		.rb(rb_raw),
		.rc(rc_raw),
		.wb(wb_even)
	);

	spu_forward u_forward (
		.ra_addr(uop_even.ra),
		.rb_addr(uop_even.rb),
		.rc_addr(uop_odd.rt),
		.ra_raw(ra_raw),
		.rb_raw(rb_raw),
		.rc_raw(rc_raw),
		.ex1(even_ex1),
		.ex2(wb_even),
		.ra(ra_fwd),
		.rb(rb_fwd),
		.rc(rc_fwd)
	);

	spu_even_pipe u_even_pipe (
		.clk(clk),
		.rst_n(rst_n),
		.uop(uop_even),
		.ra(ra_fwd),
		.rb(rb_fwd),
		.ex1(even_ex1),
		.ex2(wb_even)
	);

	spu_odd_pipe u_odd_pipe (
		.clk(clk),
		.rst_n(rst_n),
		.uop(uop_odd),
		.pc(pc),
		.cond(rc_fwd),
		.branch_taken(branch_taken),
		.pc_wb(pc_wb)
	);

endmodule

// ==== tests/tb_spu_pipes.sv ====
`timescale 1ns/10ps

module tb_spu_pipes import spu_pkg::*; ();

	logic clk;
	logic rst_n;
	instr_t instr_even;
	instr_t instr_odd;
	pc_t pc;
	wb_t wb_even;
	logic branch_taken;
	pc_t pc_wb;

	// one entry per row of the input file
	logic [7:0] row_pc [$];
	logic [31:0] row_even [$];
	logic [31:0] row_odd [$];
	logic row_wb_valid [$];
	logic [6:0] row_wb_addr [$];
	logic [127:0] row_wb_data [$];
	logic row_taken [$];
	logic [7:0] row_pc_wb [$];

	int num_rows;
	bit loaded;

	spu_pipes UUT (
		.clk(clk),
		.rst_n(rst_n),
		.instr_even(instr_even),
		.instr_odd(instr_odd),
		.pc(pc),
		.wb_even(wb_even),
		.branch_taken(branch_taken),
		.pc_wb(pc_wb)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// rows: pc, even, odd, wb valid, wb addr, wb data, taken, pc_wb
	task automatic load_rows();
		int fd;
		int code;
		logic [8*128-1:0] line;
		logic [31:0] f_pc;
		logic [31:0] f_even;
		logic [31:0] f_odd;
		logic [31:0] f_valid;
		logic [31:0] f_addr;
		logic [31:0] f_taken;
		logic [31:0] f_pcwb;
		logic [127:0] f_data;
		fd = $fopen("tests/pipes_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/pipes_input.txt");
			$display("Test failures found");
			$fatal(1, "no stimulus file");
		end else begin
			// skip the two column header lines
			code = $fgets(line, fd);
			code = $fgets(line, fd);
			code = $fscanf(fd, " %h %h %h %h %h %h %h %h", f_pc, f_even, f_odd,
				f_valid, f_addr, f_data, f_taken, f_pcwb);
			while (code == 8) begin
				row_pc.push_back(f_pc[7:0]);
				row_even.push_back(f_even);
				row_odd.push_back(f_odd);
				row_wb_valid.push_back(f_valid[0]);
				row_wb_addr.push_back(f_addr[6:0]);
				row_wb_data.push_back(f_data);
				row_taken.push_back(f_taken[0]);
				row_pc_wb.push_back(f_pcwb[7:0]);
				code = $fscanf(fd, " %h %h %h %h %h %h %h %h", f_pc, f_even, f_odd,
					f_valid, f_addr, f_data, f_taken, f_pcwb);
			end
			$fclose(fd);
			num_rows = row_pc.size();
			loaded = 1'b1;
		end
	endtask

	task automatic drive_row(input int r);
		pc = row_pc[r];
		instr_even = row_even[r];
		instr_odd = row_odd[r];
	endtask

	// zero words decode as no-write nops
	task automatic drive_idle();
		pc = '0;
		instr_even = '0;
		instr_odd = '0;
	endtask

	// branch outputs belong to the pair issued one cycle earlier
	task automatic check_branch(input int r);
		check_value($sformatf("branch_taken (row %0d)", r), branch_taken, row_taken[r]);
		check_value($sformatf("pc_wb (row %0d)", r), pc_wb, row_pc_wb[r]);
	endtask

	// writeback belongs to the pair issued two cycles earlier
	task automatic check_writeback(input int r);
		check_value($sformatf("wb_even.valid (row %0d)", r), wb_even.valid, row_wb_valid[r]);
		// addr and data only matter on a real write
		if (row_wb_valid[r]) begin
			check_value($sformatf("wb_even.addr (row %0d)", r), wb_even.addr,
				row_wb_addr[r]);
			check_value($sformatf("wb_even.data (row %0d)", r), wb_even.data,
				row_wb_data[r]);
		end
	endtask

	// run limit scales with the row count
	initial begin
		wait (loaded == 1'b1);
		#((num_rows + 10) * 100);
		$display("watchdog expired before all rows were checked");
		$display("Test failures found");
		$fatal(1, "timeout");
	end

	initial begin
		rst_n = 1'b0;
		instr_even = '0;
		instr_odd = '0;
		pc = '0;
		load_rows();
		if (num_rows == 0) begin
			$display("input file holds no stimulus rows");
			$display("Test failures found");
			$fatal(1, "empty stimulus");
		end
		// reset over four rising edges
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// outputs idle out of reset
		check_value("wb_even.valid", wb_even.valid, 1'b0);
		check_value("branch_taken", branch_taken, 1'b0);
		check_value("pc_wb", pc_wb, 8'h00);
		// two extra cycles drain the pipe
		for (int k = 0; k < num_rows + 2; k++) begin
			if (k >= 1 && k <= num_rows) begin
				check_branch(k - 1);
			end
			if (k >= 2) begin
				check_writeback(k - 2);
			end
			if (k < num_rows) begin
				drive_row(k);
			end else begin
				drive_idle();
			end
			@(negedge clk);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== tests/pipes_input.txt ====
// pc even_instr odd_instr wb_valid wb_addr wb_data(word 0 first) branch_taken pc_wb
// all hex, expected values start from all-zero registers after reset
00 4291A281 00200000 1 01 00012345000123450001234500012345 0 00
08 1C004082 00200000 1 02 00012346000123460001234600012346 0 00
10 1CFFC083 32001000 1 03 00012344000123440001234400012344 1 30
18 18008084 00200000 1 04 0002468B0002468B0002468B0002468B 0 30
20 1CFFC005 30002200 1 05 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 1 44
28 1C004006 00200000 1 06 00000001000000010000000100000001 0 44
30 18014287 00200000 1 07 FFFFFFFEFFFFFFFEFFFFFFFEFFFFFFFE 0 44
38 19018288 00200000 1 08 FFFF0000FFFF0000FFFF0000FFFF0000 0 44
40 18018289 00200000 1 09 00000000000000000000000000000000 0 44
48 0800410A 00200000 1 0A FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0 44
50 1820C20B 00200000 1 0B 00000200000002000000020000000200 0 44
58 0820C20C 00200000 1 0C 000367CF000367CF000367CF000367CF 0 44
60 4823058D 00200000 1 0D 000365CF000365CF000365CF000365CF 0 44
68 1923428E 00200000 1 0E FFFC9A30FFFC9A30FFFC9A30FFFC9A30 0 44
70 143C020F 00200000 1 0F 00000080000000800000008000000080 0 44
78 04FC0310 00200000 1 10 FFFFFFF1FFFFFFF1FFFFFFF1FFFFFFF1 0 44
80 14000204 00200000 1 04 00000000000000000000000000000000 0 44
88 1C014012 20000804 1 12 00000005000000050000000500000005 1 98
90 40200000 217FFC12 0 00 00000000000000000000000000000000 1 88
98 40200000 20000812 0 00 00000000000000000000000000000000 0 88
A0 40200000 21000804 0 00 00000000000000000000000000000000 0 88
A8 00000000 00000000 0 00 00000000000000000000000000000000 0 88
B0 FFFFFFFF FFFFFFFF 0 00 00000000000000000000000000000000 0 88
B8 18038813 30000000 1 13 FFFC9A21FFFC9A21FFFC9A21FFFC9A21 1 00
C0 40200000 00200000 0 00 00000000000000000000000000000000 0 00
C8 43FFFF94 00200000 1 14 0003FFFF0003FFFF0003FFFF0003FFFF 0 00

// ==== flist.f ====
hw/spu_pkg.sv
hw/spu_decode.sv
hw/spu_reg_table.sv
hw/spu_forward.sv
hw/spu_even_pipe.sv
hw/spu_odd_pipe.sv
hw/spu_pipes.sv
tests/tb_spu_pipes.sv

// ==== Bender.yml ====
package:
  name: spu_pipes

sources:
  - hw/spu_pkg.sv
  - hw/spu_decode.sv
  - hw/spu_reg_table.sv
  - hw/spu_forward.sv
  - hw/spu_even_pipe.sv
  - hw/spu_odd_pipe.sv
  - hw/spu_pipes.sv
  - target: test
    files:
      - tests/tb_spu_pipes.sv
